// ==== dv/cook_timer_trace.txt ====
# P key count (key 0 start, 1 second, 2 minute, 3 alarm off) | W seconds
# C value alt running alarm (value and alt in hex, either reading passes)
C 0000 0000 0 0
P 0 1
C 0000 0000 0 1
P 3 1
C 0000 0000 0 0
P 2 3
P 1 65
C 0305 0305 0 0
P 0 1
W 7
C 0258 0259 1 0
P 0 1
C 0305 0305 0 0
P 2 57
P 1 57
C 0002 0002 0 0
P 0 1
W 4
C 0002 0002 0 1
P 3 1
C 0002 0002 0 0

// ==== flist.f ====
+incdir+hw
hw/timer_pkg.sv
hw/key_if.sv
hw/key_conditioner.sv
hw/preset_counter.sv
hw/countdown_ctrl.sv
hw/fnd_scan.sv
hw/cook_timer_top.sv
dv/tb_clock.sv
dv/timer_checker.sv
dv/tb_cook_timer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cook_timer
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_cook_timer.sv ====
`timescale 1ns/1ps

module tb_cook_timer;

    localparam int clks_per_sec = 40;
    localparam int press_clks   = 12;
    localparam int done_limit   = 64;

    logic        clk;
    logic        reset_p;
    logic [3:0]  btn;
    logic [3:0]  com;
    logic [7:0]  seg_7;
    logic        led_start;
    logic        led_alarm;
    logic        buzz;
    logic        check_req;
    logic [15:0] exp_value;
    logic [15:0] exp_alt;
    logic        exp_running;
    logic        exp_alarm;
    logic        check_done;
    int          value_errors;
    int          format_errors;
    int          trace_errors;
    int          timeouts;
    int          fd;
    logic        aborted;

    tb_clock clock_gen (.clk(clk), .reset_p(reset_p));

    cook_timer_top #(.clks_per_sec(clks_per_sec), .debounce_clks(4), .scan_clks(2)) uut (
        .clk(clk), .reset_p(reset_p), .btn(btn), .com(com), .seg_7(seg_7),
        .led_start(led_start), .led_alarm(led_alarm), .buzz(buzz)
    );

    timer_checker monitor (
        .clk(clk), .reset_p(reset_p), .com(com), .seg_7(seg_7),
        .led_start(led_start), .led_alarm(led_alarm), .buzz(buzz),
        .check_req(check_req), .exp_value(exp_value), .exp_alt(exp_alt),
        .exp_running(exp_running), .exp_alarm(exp_alarm), .check_done(check_done),
        .value_errors(value_errors), .format_errors(format_errors)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Trace commands
    ////////////////////////////////////////////////////////////////////////////
    task automatic wait_for_reset();
        int n;
        n = 0;
        while (reset_p !== 1'b0 && n < 10) begin
            @(posedge clk);
            n++;
        end
        if (reset_p !== 1'b0) begin
            $display("Timeout waiting for reset to be released");
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_for_done(input logic level, input string what);
        int n;
        n = 0;
        while (check_done !== level && n < done_limit) begin
            @(posedge clk);
            n++;
        end
        if (check_done !== level) begin
            $display("Timeout waiting for the checker to %s", what);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    task automatic press_key(input logic [1:0] key, input int count);
        for (int n = 0; n < count; n++) begin
            btn[key] <= 1'b1;
            repeat (press_clks) @(posedge clk);
            btn[key] <= 1'b0;
            repeat (press_clks) @(posedge clk);
        end
    endtask

    task automatic wait_seconds(input int secs);
        for (int n = 0; n < secs * clks_per_sec; n++) begin
            @(posedge clk);
        end
    endtask

    task automatic run_check(input logic [15:0] value, input logic [15:0] alt,
                             input int running, input int alarm);
        exp_value   <= value;
        exp_alt     <= alt;
        exp_running <= running[0];
        exp_alarm   <= alarm[0];
        check_req   <= 1'b1;
        wait_for_done(1'b1, "finish a check");
        check_req <= 1'b0;
        if (!aborted) begin
            wait_for_done(1'b0, "release a check");
        end
    endtask

    task automatic report_bad_line(input logic [7:0] cmd);
        $display("Trace line for command %c cannot be read", cmd);
        trace_errors++;
        aborted = 1'b1;
    endtask

    task automatic run_command(input logic [7:0] cmd);
        int          a;
        int          b;
        int          c;
        logic [15:0] value;
        logic [15:0] alt;
        case (cmd)
            "#": begin
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end
            "P": begin
                if ($fscanf(fd, "%d %d", a, b) == 2) begin
                    press_key(a[1:0], b);
                end else begin
                    report_bad_line(cmd);
                end
            end
            "W": begin
                if ($fscanf(fd, "%d", a) == 1) begin
                    wait_seconds(a);
                end else begin
                    report_bad_line(cmd);
                end
            end
            "C": begin
                if ($fscanf(fd, "%h %h %d %d", value, alt, a, b) == 4) begin
                    run_check(value, alt, a, b);
                end else begin
                    report_bad_line(cmd);
                end
            end
            default: report_bad_line(cmd);
        endcase
    endtask

    initial begin
        logic [7:0] cmd;
        btn          = '0;
        check_req    = 1'b0;
        exp_value    = '0;
        exp_alt      = '0;
        exp_running  = 1'b0;
        exp_alarm    = 1'b0;
        trace_errors = 0;
        timeouts     = 0;
        aborted      = 1'b0;
        fd = $fopen("dv/cook_timer_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file");
            trace_errors++;
        end else begin
            wait_for_reset();
            while (!aborted && $fscanf(fd, " %c", cmd) == 1) begin
                run_command(cmd);
            end
            $fclose(fd);
        end
        repeat (4) @(posedge clk);
        $display("Errors: %0d value, %0d format, %0d trace, %0d timeout",
                 value_errors, format_errors, trace_errors, timeouts);
        if (value_errors + format_errors + trace_errors + timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== dv/timer_checker.sv ====
`timescale 1ns/1ps

module timer_checker (
    input  logic        clk,
    input  logic        reset_p,
    input  logic [3:0]  com,
    input  logic [7:0]  seg_7,
    input  logic        led_start,
    input  logic        led_alarm,
    input  logic        buzz,
    input  logic        check_req,
    input  logic [15:0] exp_value,
    input  logic [15:0] exp_alt,      // Second accepted reading
    input  logic        exp_running,
    input  logic        exp_alarm,
    output logic        check_done,
    output int          value_errors,
    output int          format_errors
);

    import timer_pkg::*;

    logic [15:0] scan_buf;
    logic [3:0]  seen;  // Digits captured in order since min10
    logic        pending;

    function automatic int digit_of_seg(seg_pattern_t pattern);
        int found;
        found = -1;
        for (int d = 0; d < 10; d++) begin
            if (seg_of_digit(bcd_digit_t'(d)) == pattern) begin
                found = d;
            end
        end
        return found;
    endfunction

    // Outputs settle after the rising edge, so sample on the falling one
    always @(negedge clk or posedge reset_p) begin
        logic [1:0]  pos;
        logic [3:0]  dig;
        logic [15:0] reading;
        int          found;
        if (reset_p) begin
            scan_buf      <= '0;
            seen          <= '0;
            pending       <= 1'b0;
            check_done    <= 1'b0;
            value_errors  = 0;
            format_errors = 0;
        end else begin
            found = digit_of_seg(seg_7);
            dig   = found[3:0];
            pos   = 2'd0;
            for (int k = 0; k < 4; k++) begin
                if (!com[k]) pos = 2'(3 - k);  // com[3] is min10
            end
            if (buzz !== led_alarm) begin
                $display("ERR buzz 0x%h, led_alarm 0x%h", buzz, led_alarm);
                value_errors++;
            end
            if ($countones(~com) != 1) begin
                $display("Digit select broken, %0d com lines low", $countones(~com));
                format_errors++;
                seen <= '0;
            end else if (found < 0) begin
                $display("Segment pattern %b is not a valid digit", seg_7);
                format_errors++;
                seen <= '0;
            end else if (pos == 2'd0) begin
                scan_buf[15:12] <= dig;
                seen            <= 4'b0001;
            end else if (seen[pos - 2'd1]) begin
                scan_buf[{~pos, 2'b00} +: 4] <= dig;  // Nibble 3 - pos
                seen[pos]                    <= 1'b1;
                if (pos == 2'd3 && pending) begin
                    reading = {scan_buf[15:4], dig};
                    if (reading !== exp_value && reading !== exp_alt) begin
                        $display("ERR display 0x%h, expected 0x%h (or 0x%h)",
                                 reading, exp_value, exp_alt);
                        value_errors++;
                    end
                    if (led_start !== exp_running) begin
                        $display("ERR led_start 0x%h, expected 0x%h", led_start, exp_running);
                        value_errors++;
                    end
                    if (led_alarm !== exp_alarm) begin
                        $display("ERR led_alarm 0x%h, expected 0x%h", led_alarm, exp_alarm);
                        value_errors++;
                    end
                    pending    <= 1'b0;
                    check_done <= 1'b1;
                end
            end
            if (check_req && !pending && !check_done) begin
                pending <= 1'b1;
                seen    <= '0;  // Only a scan begun after the request counts
            end else if (!check_req) begin
                check_done <= 1'b0;
            end
        end
    end

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset_p
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        reset_p = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset_p <= 1'b0;
    end

endmodule

// ==== hw/cook_timer_top.sv ====
`timescale 1ns/1ps
`include "timer_params.svh"

module cook_timer_top #(
    parameter int clks_per_sec  = `TIMER_CLKS_PER_SEC,
    parameter int debounce_clks = `TIMER_DEBOUNCE_CLKS,
    parameter int scan_clks     = `TIMER_SCAN_CLKS
) (
    input  logic       clk,
    input  logic       reset_p,
    input  logic [3:0] btn,        // start, sec, min, alarm off
    output logic [3:0] com,
    output logic [7:0] seg_7,
    output logic       led_start,
    output logic       led_alarm,
    output logic       buzz
);

    import timer_pkg::*;

    mmss_t preset;
    mmss_t current;
    mmss_t shown;
    logic  running;
    logic  alarm;

    key_if keys ();

    key_conditioner #(.debounce_clks(debounce_clks)) u_keys (
        .clk(clk), .reset_p(reset_p), .btn(btn), .keys(keys)
    );

    preset_counter u_preset (
        .clk(clk), .reset_p(reset_p), .keys(keys), .preset(preset)
    );

    countdown_ctrl #(.clks_per_sec(clks_per_sec)) u_count (
        .clk(clk), .reset_p(reset_p), .keys(keys), .preset(preset),
        .current(current), .running(running), .alarm(alarm)
    );

    // Countdown while running, preset otherwise
    assign shown = running ? current : preset;

    fnd_scan #(.scan_clks(scan_clks)) u_fnd (
        .clk(clk), .reset_p(reset_p), .value(shown), .com(com), .seg_7(seg_7)
    );

    assign led_start = running;
    assign led_alarm = alarm;
    assign buzz      = alarm;

endmodule

// ==== hw/fnd_scan.sv ====
`timescale 1ns/1ps
`include "timer_params.svh"

module fnd_scan #(
    parameter int scan_clks = `TIMER_SCAN_CLKS
) (
    input  logic                    clk,
    input  logic                    reset_p,
    input  timer_pkg::mmss_t        value,
    output logic [3:0]              com,
    output timer_pkg::seg_pattern_t seg_7
);

    import timer_pkg::*;

    localparam int scan_w = $clog2(scan_clks + 1);
    localparam logic [scan_w-1:0] scan_last = scan_w'(scan_clks - 1);

    logic [scan_w-1:0] scan_cnt;
    logic [1:0]        digit_idx;  // 0 is min10, leftmost
    bcd_digit_t        digit;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == scan_last) begin
            scan_cnt  <= '0;
            digit_idx <= digit_idx + 2'd1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_comb begin
        case (digit_idx)
            2'd0:    digit = value.min10;
            2'd1:    digit = value.min1;
            2'd2:    digit = value.sec10;
            default: digit = value.sec1;
        endcase
    end

    assign com   = ~(4'b1000 >> digit_idx);  // One line low, com[3] leftmost
    assign seg_7 = seg_of_digit(digit);

endmodule

// ==== hw/countdown_ctrl.sv ====
`timescale 1ns/1ps
`include "timer_params.svh"

module countdown_ctrl #(
    parameter int clks_per_sec = `TIMER_CLKS_PER_SEC
) (
    input  logic             clk,
    input  logic             reset_p,
    key_if.receiver          keys,
    input  timer_pkg::mmss_t preset,
    output timer_pkg::mmss_t current,
    output logic             running,
    output logic             alarm
);

    import timer_pkg::*;

    localparam int tick_w = $clog2(clks_per_sec + 1);
    localparam logic [tick_w-1:0] tick_last = tick_w'(clks_per_sec - 1);

    logic [tick_w-1:0] tick_cnt;
    logic              tick;
    logic              at_zero;

    // One second down, borrow from seconds into minutes
    function automatic mmss_t mmss_dec(mmss_t t);
        mmss_t next;
        next = t;
        if (t.sec1 != 4'd0) begin
            next.sec1 = t.sec1 - 4'd1;
        end else begin
            next.sec1 = 4'd9;
            if (t.sec10 != 4'd0) begin
                next.sec10 = t.sec10 - 4'd1;
            end else begin
                next.sec10 = 4'd5;
                if (t.min1 != 4'd0) begin
                    next.min1 = t.min1 - 4'd1;
                end else begin
                    next.min1  = 4'd9;
                    next.min10 = t.min10 - 4'd1;
                end
            end
        end
        return next;
    endfunction

    assign tick    = running && (tick_cnt == tick_last);
    assign at_zero = (current == '0);

    ////////////////////////////////////////////////////////////////////////
    // Seconds tick, runs only while counting
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            tick_cnt <= '0;
        end else if (!running || keys.start || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Down counter and run / alarm flags
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            current <= '0;
            running <= 1'b0;
            alarm   <= 1'b0;
        end else begin
            if (keys.start) begin
                running <= !running;  // Second press cancels
                if (!running) begin
                    current <= preset;
                end
            end else if (running && at_zero) begin
                running <= 1'b0;
            end else if (tick) begin
                current <= mmss_dec(current);
            end

            if (running && at_zero && !keys.start) begin
                alarm <= 1'b1;
            end else if (keys.alarm_off) begin
                alarm <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/preset_counter.sv ====
`timescale 1ns/1ps

module preset_counter (
    input  logic            clk,
    input  logic            reset_p,
    key_if.receiver         keys,
    output timer_pkg::mmss_t preset
);

    import timer_pkg::*;

    // Two-digit BCD step, 59 wraps to 00
    function automatic logic [7:0] bcd60_inc(bcd_digit_t tens, bcd_digit_t ones);
        logic [7:0] next;
        if (ones == 4'd9) begin
            next[3:0] = 4'd0;
            next[7:4] = (tens == 4'd5) ? 4'd0 : tens + 4'd1;
        end else begin
            next[3:0] = ones + 4'd1;
            next[7:4] = tens;
        end
        return next;
    endfunction

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            preset <= '0;
        end else begin
            if (keys.sec) begin
                {preset.sec10, preset.sec1} <= bcd60_inc(preset.sec10, preset.sec1);
            end
            if (keys.min) begin  // No carry from seconds
                {preset.min10, preset.min1} <= bcd60_inc(preset.min10, preset.min1);
            end
        end
    end

endmodule

// ==== hw/key_conditioner.sv ====
`timescale 1ns/1ps
`include "timer_params.svh"

module key_conditioner #(
    parameter int debounce_clks = `TIMER_DEBOUNCE_CLKS
) (
    input  logic        clk,
    input  logic        reset_p,
    input  logic [3:0]  btn,
    key_if.sender       keys
);

    localparam int cnt_w = $clog2(debounce_clks + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(debounce_clks - 1);

    logic [3:0]       sync_0;
    logic [3:0]       sync_1;
    logic [3:0]       level;  // Accepted button state
    logic [3:0]       pulse;
    logic [cnt_w-1:0] stable_cnt [4];

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            sync_0 <= '0;
            sync_1 <= '0;
            level  <= '0;
            pulse  <= '0;
            for (int i = 0; i < 4; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            sync_0 <= btn;
            sync_1 <= sync_0;
            for (int i = 0; i < 4; i++) begin
                pulse[i] <= 1'b0;
                if (sync_1[i] == level[i]) begin
                    stable_cnt[i] <= '0;  // Bounce restarts the wait
                end else if (stable_cnt[i] == cnt_last) begin
                    stable_cnt[i] <= '0;
                    level[i]      <= sync_1[i];
                    pulse[i]      <= sync_1[i];  // Press only, release is silent
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    assign keys.start     = pulse[0];
    assign keys.sec       = pulse[1];
    assign keys.min       = pulse[2];
    assign keys.alarm_off = pulse[3];

endmodule

// ==== hw/key_if.sv ====
`timescale 1ns/1ps

// One-cycle button pulses, no handshake
interface key_if;

    logic start;
    logic sec;
    logic min;
    logic alarm_off;

    modport sender (
        output start, sec, min, alarm_off
    );

    modport receiver (
        input start, sec, min, alarm_off
    );

endinterface

// ==== hw/timer_pkg.sv ====
package timer_pkg;

    typedef logic [3:0] bcd_digit_t;

    // Field order matches the display, min10 leftmost
    typedef struct packed {
        bcd_digit_t min10;
        bcd_digit_t min1;
        bcd_digit_t sec10;
        bcd_digit_t sec1;
    } mmss_t;

    typedef logic [7:0] seg_pattern_t;  // {a, b, c, d, e, f, g, dp}, low lights

    function automatic seg_pattern_t seg_of_digit(bcd_digit_t digit);
        seg_pattern_t pattern;
        case (digit)
            4'd0: pattern = 8'b0000_0011;
            4'd1: pattern = 8'b1001_1111;
            4'd2: pattern = 8'b0010_0101;
            4'd3: pattern = 8'b0000_1101;
            4'd4: pattern = 8'b1001_1001;
            4'd5: pattern = 8'b0100_1001;
            4'd6: pattern = 8'b0100_0001;
            4'd7: pattern = 8'b0001_1111;
            4'd8: pattern = 8'b0000_0001;
            4'd9: pattern = 8'b0000_1001;
            default: pattern = 8'b1111_1111;  // Blank for non-BCD
        endcase
        return pattern;
    endfunction

endpackage

// ==== hw/timer_params.svh ====
`ifndef TIMER_PARAMS_SVH
`define TIMER_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Board defaults for a 100 MHz clock
////////////////////////////////////////////////////////////////////////////

// Clock cycles per timer second
`define TIMER_CLKS_PER_SEC 100000000

// 10 ms of stable input before a button counts
`define TIMER_DEBOUNCE_CLKS 1000000

`define TIMER_SCAN_CLKS 100000  // 1 ms per digit

`endif
